// File: hw/readout_link_defs.svh
`ifndef READOUT_LINK_DEFS_SVH
`define READOUT_LINK_DEFS_SVH

// memory side of the readout path
`define READOUT_MEM_WIDTH 128           // bits in one memory burst

// serial link side
`define READOUT_LINK_WIDTH 32           // bits in one link word

// words cut out of every burst, least significant first
`define READOUT_WORDS_PER_BURST 4

// flops behind the asynchronous pause and request levels
`define READOUT_SYNC_STAGES 2

`endif

// File: hw/readout_pkg.sv
`default_nettype none

`include "readout_link_defs.svh"

package readout_pkg;

  ///////////////////////////////////////////////////////////////////////
  // data words
  typedef logic [`READOUT_MEM_WIDTH-1:0] mem_burst_t;   // one burst from memory
  typedef logic [`READOUT_LINK_WIDTH-1:0] link_word_t;  // one word to the master

  // which word of a burst is on the link
  typedef logic [$clog2(`READOUT_WORDS_PER_BURST)-1:0] word_index_t;

  ///////////////////////////////////////////////////////////////////////
  // owner of the outgoing link
  typedef enum logic [1:0] {
    src_command = 2'd0,   // command responses
    src_drain   = 2'd1,   // request seen, finish the open packet first
    src_memory  = 2'd2,   // fill data
    src_release = 2'd3    // fill done, ack up, wait for req to drop
  } link_source_e;

endpackage

`default_nettype wire

// File: hw/link_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// one 32-bit valid/ready stream with a packet end marker
interface link_stream_if;

  readout_pkg::link_word_t tdata;   // payload word
  logic tvalid;                     // source has a word
  logic tlast;                      // last word of a packet
  logic tready;                     // sink takes the word this edge

  // the side that produces words
  modport source (
    output tdata,
    output tvalid,
    output tlast,
    input  tready
  );

  // the side that consumes them
  modport sink (
    input  tdata,
    input  tvalid,
    input  tlast,
    output tready
  );

endinterface

`default_nettype wire

// File: hw/burst_width_converter.sv
`timescale 1ns/100ps
`default_nettype none

`include "readout_link_defs.svh"

// cuts each 128-bit memory burst into four link words
module burst_width_converter (
  input  logic                    clk125,
  input  logic                    reset,
  input  readout_pkg::mem_burst_t mem_tdata,   // burst from memory
  input  logic                    mem_tvalid,
  input  logic                    mem_tlast,   // last burst of the fill
  output logic                    mem_tready,
  link_stream_if.source           words        // link words toward the mux
);

  readout_pkg::mem_burst_t  burst_q;     // burst being sent
  readout_pkg::word_index_t index_q;     // word now offered
  logic                     last_q;      // burst carried mem_tlast
  logic                     full_q;      // burst_q holds words not yet sent

  logic last_word;                       // index_q points at the top word
  logic word_taken;                      // link took a word this cycle
  logic burst_taken;                     // new burst loads this cycle

  //////////////////////////////////////////////////////////////////////
  // handshake decode
  assign last_word   = (index_q == readout_pkg::word_index_t'(`READOUT_WORDS_PER_BURST - 1));
  assign word_taken  = words.tvalid && words.tready;

  // room when empty, or when the top word leaves on this edge
  assign mem_tready  = !full_q || (word_taken && last_word);
  assign burst_taken = mem_tvalid && mem_tready;

  //////////////////////////////////////////////////////////////////////
  // word select, least significant word first
  assign words.tdata  = burst_q[index_q * `READOUT_LINK_WIDTH +: `READOUT_LINK_WIDTH];
  assign words.tvalid = full_q;
  assign words.tlast  = full_q && last_q && last_word;  // only word 3 of the final burst

  // payload, loaded on accept only
  always_ff @(posedge clk125) begin
    if (burst_taken) begin
      burst_q <= mem_tdata;
    end
  end

  // word counter and occupancy
  always_ff @(posedge clk125) begin
    if (reset) begin
      full_q  <= 1'b0;
      index_q <= '0;
      last_q  <= 1'b0;
    end else if (burst_taken) begin
      full_q  <= 1'b1;       // word 0 valid next cycle
      index_q <= '0;
      last_q  <= mem_tlast;
    end else if (word_taken) begin
      if (last_word) begin
        full_q  <= 1'b0;     // burst used up, nothing waiting
        index_q <= '0;
      end else begin
        index_q <= index_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/readout_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "readout_link_defs.svh"

// picks the link owner and runs the four-phase readout handshake
module readout_sequencer (
  input  logic clk125,
  input  logic reset,
  input  logic readout_req,      // from master, asynchronous level
  output logic readout_ack,      // fill sent, held until req drops
  input  logic cmd_taken,        // link took a command word
  input  logic cmd_last_taken,   // ... and it closed a packet
  input  logic mem_last_taken,   // link took the last fill word
  output logic use_memory        // mux selects memory words
);

  logic [`READOUT_SYNC_STAGES-1:0] req_sync_q;  // request synchronizer
  logic                            req;         // synchronized request

  logic packet_open_q;   // a command packet has started and not ended
  logic packet_open_d;   // flag including the beat taken this cycle

  readout_pkg::link_source_e state_q, state_d;

  //////////////////////////////////////////////////////////////////////
  // request synchronizer
  always_ff @(posedge clk125) begin
    if (reset) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[`READOUT_SYNC_STAGES-2:0], readout_req};
    end
  end

  assign req = req_sync_q[`READOUT_SYNC_STAGES-1];

  //////////////////////////////////////////////////////////////////////
  // command packet tracking
  always_comb begin
    packet_open_d = packet_open_q;
    if (cmd_taken) begin
      packet_open_d = !cmd_last_taken;   // word without tlast opens, with tlast closes
    end
  end

  always_ff @(posedge clk125) begin
    if (reset) begin
      packet_open_q <= 1'b0;
    end else begin
      packet_open_q <= packet_open_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // source selection
  always_comb begin
    state_d = state_q;
    case (state_q)
      readout_pkg::src_command: begin
        if (req) begin
          // never cut a packet that is still going out
          state_d = packet_open_d ? readout_pkg::src_drain : readout_pkg::src_memory;
        end
      end
      readout_pkg::src_drain: begin
        if (cmd_last_taken) state_d = readout_pkg::src_memory;
      end
      readout_pkg::src_memory: begin
        if (mem_last_taken) state_d = readout_pkg::src_release;  // ack rises here
      end
      readout_pkg::src_release: begin
        if (!req) state_d = readout_pkg::src_command;            // master let go
      end
      default: state_d = readout_pkg::src_command;
    endcase
  end

  always_ff @(posedge clk125) begin
    if (reset) begin
      state_q <= readout_pkg::src_command;
    end else begin
      state_q <= state_d;
    end
  end

  // outputs straight from the state register
  assign use_memory  = (state_q == readout_pkg::src_memory);
  assign readout_ack = (state_q == readout_pkg::src_release);

endmodule

`default_nettype wire

// File: hw/link_source_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "readout_link_defs.svh"

// 2:1 stream mux in front of the link, with the master's pause
module link_source_mux (
  input  logic                    clk125,
  input  logic                    reset,
  input  logic                    readout_pause,   // asynchronous hold from master
  input  logic                    use_memory,      // from the sequencer
  input  readout_pkg::link_word_t cmd_tdata,
  input  logic                    cmd_tvalid,
  input  logic                    cmd_tlast,
  output logic                    cmd_tready,
  link_stream_if.sink             mem_words,       // words from the converter
  output readout_pkg::link_word_t link_tdata,
  output logic                    link_tvalid,
  output logic                    link_tlast,
  input  logic                    link_tready,
  output logic                    cmd_taken,       // pulses back to the sequencer
  output logic                    cmd_last_taken,
  output logic                    mem_last_taken
);

  logic [`READOUT_SYNC_STAGES-1:0] pause_sync_q;
  logic                            pause;          // synchronized pause
  logic                            link_go;        // link may take a word

  //////////////////////////////////////////////////////////////////////
  // pause synchronizer
  always_ff @(posedge clk125) begin
    if (reset) begin
      pause_sync_q <= '0;
    end else begin
      pause_sync_q <= {pause_sync_q[`READOUT_SYNC_STAGES-2:0], readout_pause};
    end
  end

  assign pause   = pause_sync_q[`READOUT_SYNC_STAGES-1];
  assign link_go = link_tready && !pause;

  //////////////////////////////////////////////////////////////////////
  // forward path, no register
  assign link_tdata  = use_memory ? mem_words.tdata : cmd_tdata;
  assign link_tlast  = use_memory ? mem_words.tlast : cmd_tlast;
  assign link_tvalid = !pause && (use_memory ? mem_words.tvalid : cmd_tvalid);

  // ready goes only to the selected source
  assign cmd_tready      = !use_memory && link_go;
  assign mem_words.tready = use_memory && link_go;

  // accepted beats, reported per kind
  assign cmd_taken      = cmd_tvalid && cmd_tready;
  assign cmd_last_taken = cmd_taken && cmd_tlast;
  assign mem_last_taken = mem_words.tvalid && mem_words.tready && mem_words.tlast;

endmodule

`default_nettype wire

// File: hw/readout_link.sv
`timescale 1ns/100ps
`default_nettype none

// readout path toward the master link
module readout_link (
  input  logic                    clk125,
  input  logic                    reset,
  // command responses
  input  readout_pkg::link_word_t cmd_tdata,
  input  logic                    cmd_tvalid,
  input  logic                    cmd_tlast,
  output logic                    cmd_tready,
  // fill data from memory
  input  readout_pkg::mem_burst_t mem_tdata,
  input  logic                    mem_tvalid,
  input  logic                    mem_tlast,     // last burst of the fill
  output logic                    mem_tready,
  // outgoing link
  output readout_pkg::link_word_t link_tdata,
  output logic                    link_tvalid,
  output logic                    link_tlast,
  input  logic                    link_tready,
  // master control
  input  logic                    readout_pause, // asynchronous
  input  logic                    readout_req,
  output logic                    readout_ack
);

  logic use_memory;       // sequencer picks memory words
  logic cmd_taken;        // accepted-beat pulses from the mux
  logic cmd_last_taken;
  logic mem_last_taken;

  link_stream_if mem_words ();   // converter to mux

  ////////////////////////////////////////////////////////////////////////
  // memory bursts to link words
  burst_width_converter converter_i (
    .clk125     (clk125),
    .reset      (reset),
    .mem_tdata  (mem_tdata),
    .mem_tvalid (mem_tvalid),
    .mem_tlast  (mem_tlast),
    .mem_tready (mem_tready),
    .words      (mem_words.source)
  );

  // link owner and req/ack
  readout_sequencer sequencer_i (
    .clk125         (clk125),
    .reset          (reset),
    .readout_req    (readout_req),
    .readout_ack    (readout_ack),
    .cmd_taken      (cmd_taken),
    .cmd_last_taken (cmd_last_taken),
    .mem_last_taken (mem_last_taken),
    .use_memory     (use_memory)
  );

  ////////////////////////////////////////////////////////////////////////
  // shared link stream
  link_source_mux mux_i (
    .clk125         (clk125),
    .reset          (reset),
    .readout_pause  (readout_pause),
    .use_memory     (use_memory),
    .cmd_tdata      (cmd_tdata),
    .cmd_tvalid     (cmd_tvalid),
    .cmd_tlast      (cmd_tlast),
    .cmd_tready     (cmd_tready),
    .mem_words      (mem_words.sink),
    .link_tdata     (link_tdata),
    .link_tvalid    (link_tvalid),
    .link_tlast     (link_tlast),
    .link_tready    (link_tready),
    .cmd_taken      (cmd_taken),
    .cmd_last_taken (cmd_last_taken),
    .mem_last_taken (mem_last_taken)
  );

endmodule

`default_nettype wire

// File: verification/readout_link_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "readout_link_defs.svh"

module readout_link_tb;

  localparam int TIMEOUT = 1000;                 // cycles allowed per wait
  localparam logic [31:0] SEED = 32'h082b2559;
  localparam int LW = `READOUT_LINK_WIDTH;
  localparam int MW = `READOUT_MEM_WIDTH;

  logic clk125 = 1'b0;
  logic reset;
  logic cmd_tvalid;
  logic cmd_tlast;
  logic cmd_tready;
  logic mem_tvalid;
  logic mem_tlast;
  logic mem_tready;
  logic link_tvalid;
  logic link_tlast;
  logic readout_pause;
  logic readout_req;
  logic readout_ack;
  logic link_tready = 1'b1;
  readout_pkg::link_word_t cmd_tdata;
  readout_pkg::link_word_t link_tdata;
  readout_pkg::mem_burst_t mem_tdata;

  logic [LW:0] cmd_q[$];    // {tlast, word} still to drive
  logic [MW:0] mem_q[$];    // {tlast, burst} still to drive
  logic [LW:0] exp_q[$];    // what the link must carry in order
  logic [LW:0] rx_q[$];     // what it did carry
  int rx_total = 0;
  int value_errors = 0;
  int timeout_errors = 0;
  logic [31:0] lfsr_q = SEED;        // stimulus data
  logic [31:0] ready_lfsr_q = SEED;  // link_tready pattern with its own state
  logic random_ready = 1'b0;

  readout_link dut_i (.*);

  always #2 clk125 = ~clk125;   // 4 ns

  ///////////////////////////////////////////////////////////////////////
  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};   // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  always @(posedge clk125) begin   // link monitor
    if (link_tvalid && link_tready) begin
      rx_q.push_back({link_tlast, link_tdata});
      rx_total++;
    end
  end

  always @(posedge clk125) begin   // master side ready
    #1;
    if (random_ready) begin
      ready_lfsr_q = lfsr_next(ready_lfsr_q);   // one step per ready bit
      link_tready = ready_lfsr_q[0];
    end else begin
      link_tready = 1'b1;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // checks and waits
  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("Error: %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_timeout(string what);
    timeout_errors++;
    $display("%0t: gave up waiting for %s", $time, what);
  endtask

  task automatic wait_rx(int count);
    int cycles;
    cycles = 0;
    while (rx_total < count && cycles < TIMEOUT) begin
      @(posedge clk125);
      #1;
      cycles++;
    end
    if (rx_total < count) report_timeout("words on the link");
  endtask

  task automatic wait_ack(logic level);
    int cycles;
    cycles = 0;
    while (readout_ack !== level && cycles < TIMEOUT) begin
      @(posedge clk125);
      #1;
      cycles++;
    end
    if (readout_ack !== level) report_timeout("readout_ack to change");
  endtask

  task automatic check_stream();
    logic [LW:0] expected;
    logic [LW:0] actual;
    int cycles;
    cycles = 0;
    while (rx_q.size() < exp_q.size() && cycles < TIMEOUT) begin
      @(posedge clk125);
      #1;
      cycles++;
    end
    if (rx_q.size() < exp_q.size()) report_timeout("the expected link words");
    while (exp_q.size() > 0 && rx_q.size() > 0) begin
      expected = exp_q.pop_front();
      actual = rx_q.pop_front();
      check_value("link_tdata", expected[LW-1:0], actual[LW-1:0]);
      check_value("link_tlast", 32'(expected[LW]), 32'(actual[LW]));
    end
    assert (rx_q.size() == 0) else begin
      value_errors++;
      $display("%0t: link carried %0d words that were never sent", $time, rx_q.size());
    end
    exp_q.delete();
    rx_q.delete();
  endtask

  ///////////////////////////////////////////////////////////////////////
  // stimulus
  task automatic queue_cmd_packet(int len);
    logic [LW:0] beat;
    for (int i = 0; i < len; i++) begin
      beat = {i == len - 1, rand_bits(LW)};   // tlast on the final word
      cmd_q.push_back(beat);
      exp_q.push_back(beat);
    end
  endtask

  task automatic queue_fill(int bursts);
    readout_pkg::mem_burst_t burst;
    for (int b = 0; b < bursts; b++) begin
      burst = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
      mem_q.push_back({b == bursts - 1, burst});
      for (int w = 0; w < `READOUT_WORDS_PER_BURST; w++) begin   // low word first
        exp_q.push_back({(b == bursts - 1) && (w == `READOUT_WORDS_PER_BURST - 1),
                         burst[w*LW +: LW]});
      end
    end
  endtask

  task automatic drive_cmd();
    int cycles;
    while (cmd_q.size() > 0) begin
      {cmd_tlast, cmd_tdata} = cmd_q.pop_front();
      cmd_tvalid = 1'b1;
      cycles = 0;
      do begin
        @(posedge clk125);
        cycles++;
      end while (!cmd_tready && cycles < TIMEOUT);
      if (!cmd_tready) begin
        report_timeout("cmd_tready");
        cmd_q.delete();
      end
      #1;
    end
    cmd_tvalid = 1'b0;
    cmd_tlast  = 1'b0;
  endtask

  task automatic drive_mem();
    int cycles;
    while (mem_q.size() > 0) begin
      {mem_tlast, mem_tdata} = mem_q.pop_front();
      mem_tvalid = 1'b1;
      cycles = 0;
      do begin
        @(posedge clk125);
        cycles++;
      end while (!mem_tready && cycles < TIMEOUT);
      if (!mem_tready) begin
        report_timeout("mem_tready");
        mem_q.delete();
      end
      #1;
    end
    mem_tvalid = 1'b0;
    mem_tlast  = 1'b0;
  endtask

  task automatic finish_readout();
    wait_ack(1'b1);
    check_value("link word count at readout_ack", exp_q.size(), rx_q.size());
    readout_req = 1'b0;
    wait_ack(1'b0);   // second half of the four-phase exchange
  endtask

  ///////////////////////////////////////////////////////////////////////
  // directed tests
  task automatic test_reset_state();
    check_value("link_tvalid", 0, 32'(link_tvalid));
    check_value("readout_ack", 0, 32'(readout_ack));
    check_value("mem_tready", 1, 32'(mem_tready));   // converter empty
    check_value("cmd_tready", 1, 32'(cmd_tready));   // commands own an idle link
  endtask

  task automatic test_commands(int packets);
    for (int p = 0; p < packets; p++) begin
      queue_cmd_packet(1 + rand_bits(2));
    end
    drive_cmd();
    check_value("readout_ack", 0, 32'(readout_ack));
    check_stream();
  endtask

  task automatic test_readout(int bursts);
    queue_fill(bursts);
    readout_req = 1'b1;
    drive_mem();
    finish_readout();
    queue_cmd_packet(3);   // commands own the link again
    drive_cmd();
    check_stream();
  endtask

  task automatic test_request_mid_packet();
    queue_cmd_packet(8);
    queue_fill(2);         // whole packet goes out before the fill
    fork
      drive_cmd();
      begin
        wait_rx(rx_total + 2);
        readout_req = 1'b1;
        drive_mem();
      end
    join
    finish_readout();
    check_stream();
  endtask

  task automatic test_pause();
    queue_cmd_packet(10);
    fork
      drive_cmd();
      begin
        wait_rx(rx_total + 3);
        readout_pause = 1'b1;
        repeat (4) @(posedge clk125);   // sync stages plus margin
        #1;
        for (int i = 0; i < 10; i++) begin
          @(posedge clk125);
          check_value("link_tvalid", 0, 32'(link_tvalid));
          check_value("cmd_tready", 0, 32'(cmd_tready));   // command word held back
        end
        #1;
        readout_pause = 1'b0;
      end
    join
    check_stream();
  endtask

  initial begin
    reset = 1'b1;
    cmd_tdata = '0;
    cmd_tvalid = 1'b0;
    cmd_tlast = 1'b0;
    mem_tdata = '0;
    mem_tvalid = 1'b0;
    mem_tlast = 1'b0;
    readout_pause = 1'b0;
    readout_req = 1'b0;
    repeat (3) @(posedge clk125);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_commands(4);
    test_readout(3);
    test_request_mid_packet();
    test_pause();
    random_ready = 1'b1;   // master stalls at random from here on
    test_commands(6);
    test_readout(5);
    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors + timeout_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: readout_link.f
+incdir+hw
hw/readout_pkg.sv
hw/link_stream_if.sv
hw/burst_width_converter.sv
hw/readout_sequencer.sv
hw/link_source_mux.sv
hw/readout_link.sv
verification/readout_link_tb.sv

// File: Makefile
# Verilator build for the readout link testbench

VERILATOR ?= verilator
TOP       ?= readout_link_tb
FILELIST  ?= readout_link.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
